/* build.f */
src/axi_perf_pkg.sv
src/stat_regs_pkg.sv
src/stat_counter.sv
src/stat_value.sv
src/axi_wr_stats.sv
src/stat_csr.sv
src/axi_wr_perf_top.sv
verif/axi_wr_perf_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module axi_wr_perf_tb

output=$(./obj_dir/Vaxi_wr_perf_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

/* src/axi_perf_pkg.sv */
`default_nettype none

package axi_perf_pkg;

  // axi write bus widths
  localparam int axi_addr_width = 20;
  localparam int axi_data_width = 16;
  localparam int axi_strb_width = axi_data_width / 8;
  localparam int axi_id_width   = 4;

  // every statistic is this wide
  localparam int stat_width = 32;

  // index 0 is the control slot, 1..25 are statistics
  localparam int num_stats = 26;

  typedef logic [axi_addr_width-1:0] axi_addr_t;
  typedef logic [axi_data_width-1:0] axi_data_t;
  typedef logic [axi_strb_width-1:0] axi_strb_t;
  typedef logic [axi_id_width-1:0]   axi_id_t;

  // burst length minus one
  typedef logic [7:0] axi_len_t;

  // log2 of bytes per beat
  typedef logic [2:0] axi_size_t;

  typedef logic [stat_width-1:0] stat_t;

  typedef logic [$clog2(num_stats)-1:0] stat_sel_t;

endpackage

`default_nettype wire

/* src/axi_wr_perf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_perf_top
  import axi_perf_pkg::*;
  import stat_regs_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,

  // monitored write channels
  input  wire       awvalid,
  input  wire       awready,
  input  axi_addr_t awaddr,
  input  axi_id_t   awid,
  input  axi_len_t  awlen,
  input  axi_size_t awsize,
  input  wire [1:0] awburst,
  input  wire       wvalid,
  input  wire       wready,
  input  wire       wlast,
  input  axi_data_t wdata,
  input  axi_strb_t wstrb,
  input  wire       bvalid,
  input  wire       bready,
  input  axi_id_t   bid,
  input  wire [1:0] bresp,

  // register access
  input  wire       wb_cyc,
  input  wire       wb_stb,
  input  wire       wb_we,
  input  wb_addr_t  wb_adr,
  input  wb_data_t  wb_dat_w,
  output wb_data_t  wb_dat_r,
  output logic      wb_ack
);

  stat_sel_t stat_sel;
  stat_t     stat_rdata;
  logic      stat_err;
  logic      stat_clear;

  axi_wr_stats i_stats (
    .clk(clk), .rst_n(rst_n), .stat_clear(stat_clear),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid),
    .awlen(awlen), .awsize(awsize), .awburst(awburst),
    .wvalid(wvalid), .wready(wready), .wlast(wlast), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
    .stat_sel(stat_sel), .stat_rdata(stat_rdata), .stat_err(stat_err)
  );

  stat_csr i_csr (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .stat_sel(stat_sel), .stat_rdata(stat_rdata), .stat_err(stat_err),
    .stat_clear(stat_clear)
  );

endmodule

`default_nettype wire

/* src/axi_wr_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_stats
  import axi_perf_pkg::*;
  import stat_regs_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       stat_clear,

  input  wire       awvalid,
  input  wire       awready,
  input  axi_addr_t awaddr,
  input  axi_id_t   awid,
  input  axi_len_t  awlen,
  input  axi_size_t awsize,
  input  wire [1:0] awburst,

  input  wire       wvalid,
  input  wire       wready,
  input  wire       wlast,
  input  axi_data_t wdata,
  input  axi_strb_t wstrb,

  input  wire       bvalid,
  input  wire       bready,
  input  axi_id_t   bid,
  input  wire [1:0] bresp,

  input  stat_sel_t stat_sel,
  output stat_t     stat_rdata,
  output logic      stat_err
);

  logic aw_hs;
  logic w_hs;
  logic w_last_hs;
  logic b_hs;

  stat_t aw_bursts;
  stat_t w_bursts;
  stat_t w_beats;
  stat_t aw_out_cnt;
  stat_t aw_out_max;
  stat_t w_out_cnt;
  stat_t w_out_max;
  logic  aw_underflow;
  logic  w_underflow;

  axi_len_t awlen_min;
  axi_len_t awlen_max;

  stat_t aw_bytes;
  stat_t aw_bytes_min;
  stat_t aw_bytes_max;
  stat_t aw_bytes_sum;

  logic [axi_strb_width:0] w_bytes;
  logic [axi_strb_width:0] w_bytes_min;
  logic [axi_strb_width:0] w_bytes_max;
  stat_t                   w_bytes_sum;

  logic w_in_progress;

  // one bit per bin, in register order idle..b_end
  logic [11:0] bin_hit;
  stat_t       bin_cnt [12];

  assign aw_hs     = awvalid && awready;
  assign w_hs      = wvalid && wready;
  assign w_last_hs = w_hs && wlast;
  assign b_hs      = bvalid && bready;

  stat_counter i_aw_bursts (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .inc(aw_hs), .dec(1'b0),
    .cnt(aw_bursts), .peak(), .underflow()
  );

  stat_counter i_w_bursts (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .inc(w_last_hs), .dec(1'b0),
    .cnt(w_bursts), .peak(), .underflow()
  );

  stat_counter i_w_beats (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .inc(w_hs), .dec(1'b0),
    .cnt(w_beats), .peak(), .underflow()
  );

  // address accepted until its response
  stat_counter i_aw_outstanding (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .inc(aw_hs), .dec(b_hs),
    .cnt(aw_out_cnt), .peak(aw_out_max), .underflow(aw_underflow)
  );

  // last data beat accepted until its response
  stat_counter i_w_outstanding (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .inc(w_last_hs), .dec(b_hs),
    .cnt(w_out_cnt), .peak(w_out_max), .underflow(w_underflow)
  );

  stat_value #(.width(8)) i_awlen (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .en(aw_hs), .val(awlen),
    .min_val(awlen_min), .max_val(awlen_max), .sum()
  );

  // bytes per burst
  assign aw_bytes = (stat_t'(awlen) + stat_t'(1)) << awsize;

  stat_value #(.width(stat_width)) i_aw_bytes (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .en(aw_hs), .val(aw_bytes),
    .min_val(aw_bytes_min), .max_val(aw_bytes_max), .sum(aw_bytes_sum)
  );

  // enabled bytes in this beat
  always_comb begin
    w_bytes = '0;
    for (int i = 0; i < axi_strb_width; i++) begin
      w_bytes = w_bytes + (axi_strb_width + 1)'(wstrb[i]);
    end
  end

  stat_value #(.width(axi_strb_width + 1)) i_w_bytes (
    .clk(clk), .rst_n(rst_n), .clear(stat_clear), .en(w_hs), .val(w_bytes),
    .min_val(w_bytes_min), .max_val(w_bytes_max), .sum(w_bytes_sum)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_in_progress <= 1'b0;
    end else if (wvalid) begin
      w_in_progress <= !(wready && wlast);
    end
  end

  // first matching row wins
  always_comb begin
    bin_hit = '0;
    casez ({aw_out_cnt != '0, w_out_cnt != '0, w_in_progress,
            awvalid, awready, wvalid, wready, bvalid, bready})
      9'b0000?0???: bin_hit[0]  = 1'b1;
      9'b1?1??0???: bin_hit[1]  = 1'b1;
      9'b1????10??: bin_hit[2]  = 1'b1;
      9'b0?1??10??: bin_hit[2]  = 1'b1;
      9'b0??0?11??: bin_hit[3]  = 1'b1;
      9'b000110???: bin_hit[4]  = 1'b1;
      9'b000100???: bin_hit[5]  = 1'b1;
      9'b100??0???: bin_hit[6]  = 1'b1;
      9'b010??0???: bin_hit[7]  = 1'b1;
      9'b0?1??0???: bin_hit[7]  = 1'b1;
      9'b0?0??10??: bin_hit[8]  = 1'b1;
      9'b110??0?0?: bin_hit[9]  = 1'b1;
      9'b110??0?10: bin_hit[10] = 1'b1;
      9'b110??0?11: bin_hit[11] = 1'b1;
      default:      bin_hit     = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 12; i++) begin
      if (!rst_n || stat_clear) begin
        bin_cnt[i] <= '0;
      end else if (bin_hit[i]) begin
        bin_cnt[i] <= bin_cnt[i] + stat_t'(1);
      end
    end
  end

  // sticky until reset or clear
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      stat_err <= 1'b0;
    end else if (aw_underflow || w_underflow) begin
      stat_err <= 1'b1;
    end
  end

  always_comb begin
    case (stat_sel)
      reg_aw_bursts:          stat_rdata = aw_bursts;
      reg_w_bursts:           stat_rdata = w_bursts;
      reg_w_beats:            stat_rdata = w_beats;
      reg_awlen_min:          stat_rdata = stat_t'(awlen_min);
      reg_awlen_max:          stat_rdata = stat_t'(awlen_max);
      reg_aw_bytes_min:       stat_rdata = aw_bytes_min;
      reg_aw_bytes_max:       stat_rdata = aw_bytes_max;
      reg_aw_bytes_sum:       stat_rdata = aw_bytes_sum;
      reg_w_bytes_min:        stat_rdata = stat_t'(w_bytes_min);
      reg_w_bytes_max:        stat_rdata = stat_t'(w_bytes_max);
      reg_w_bytes_sum:        stat_rdata = w_bytes_sum;
      reg_aw_outstanding_max: stat_rdata = aw_out_max;
      reg_w_outstanding_max:  stat_rdata = w_out_max;
      reg_idle:               stat_rdata = bin_cnt[0];
      reg_slow_data:          stat_rdata = bin_cnt[1];
      reg_stall:              stat_rdata = bin_cnt[2];
      reg_early_beat:         stat_rdata = bin_cnt[3];
      reg_awr_early:          stat_rdata = bin_cnt[4];
      reg_addr_stall:         stat_rdata = bin_cnt[5];
      reg_data_lag:           stat_rdata = bin_cnt[6];
      reg_addr_lag:           stat_rdata = bin_cnt[7];
      reg_early_stall:        stat_rdata = bin_cnt[8];
      reg_b_lag:              stat_rdata = bin_cnt[9];
      reg_b_stall:            stat_rdata = bin_cnt[10];
      reg_b_end:              stat_rdata = bin_cnt[11];
      // control slot and unused indices
      default:                stat_rdata = '0;
    endcase
  end

  a_wlast_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (wready && wlast) |-> wvalid)
    else $error("axi_wr_stats: wlast accepted without wvalid");

endmodule

`default_nettype wire

/* src/stat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module stat_counter
  import axi_perf_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  input  wire   clear,
  input  wire   inc,
  input  wire   dec,
  output stat_t cnt,
  output stat_t peak,
  output logic  underflow
);

  stat_t cnt_next;

  // inc and dec in the same cycle cancel out
  always_comb begin
    cnt_next = cnt;
    if (inc && !dec) begin
      cnt_next = cnt + stat_t'(1);
    end else if (dec && !inc && cnt != '0) begin
      cnt_next = cnt - stat_t'(1);
    end
  end

  // a decrement with nothing left to take away
  assign underflow = dec && !inc && (cnt == '0);

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      cnt  <= '0;
      peak <= '0;
    end else begin
      cnt <= cnt_next;
      if (cnt_next > peak) begin
        peak <= cnt_next;
      end
    end
  end

  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n || clear)
    (inc && !dec) |-> (cnt != '1))
    else $error("stat_counter: count wrapped past its maximum");

endmodule

`default_nettype wire

/* src/stat_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module stat_csr
  import axi_perf_pkg::*;
  import stat_regs_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,

  input  wire       wb_cyc,
  input  wire       wb_stb,
  input  wire       wb_we,
  input  wb_addr_t  wb_adr,
  input  wb_data_t  wb_dat_w,
  output wb_data_t  wb_dat_r,
  output logic      wb_ack,

  output stat_sel_t stat_sel,
  input  stat_t     stat_rdata,
  input  wire       stat_err,
  output logic      stat_clear
);

  typedef enum logic {
    st_idle,
    st_ack
  } state_t;

  state_t   state;
  logic     req;
  wb_data_t ctrl_rdata;

  // a new request is only taken from idle
  assign req = wb_cyc && wb_stb && (state == st_idle);

  assign stat_sel   = stat_sel_t'(wb_adr);
  assign ctrl_rdata = wb_data_t'(stat_err);
  assign wb_ack     = (state == st_ack);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_idle;
      stat_clear <= 1'b0;
    end else begin
      stat_clear <= 1'b0;
      case (state)
        st_idle: begin
          if (req) begin
            state <= st_ack;
            // clear pulse lines up with ack
            if (wb_we && wb_adr == reg_ctrl && wb_dat_w[ctrl_clear_bit]) begin
              stat_clear <= 1'b1;
            end
          end
        end
        st_ack: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // read data is captured on the edge that raises ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= (wb_adr == reg_ctrl) ? ctrl_rdata : stat_rdata;
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("stat_csr: ack held for two cycles");

endmodule

`default_nettype wire

/* src/stat_regs_pkg.sv */
`default_nettype none

package stat_regs_pkg;

  // wishbone word address and data widths
  localparam int wb_addr_width = 5;
  localparam int wb_data_width = 32;

  typedef logic [wb_addr_width-1:0] wb_addr_t;
  typedef logic [wb_data_width-1:0] wb_data_t;

  // control: read gives stat_err in bit 0, write bit 0 clears
  localparam wb_addr_t reg_ctrl = 5'd0;
  localparam int ctrl_clear_bit = 0;

  // statistic registers, index matches the monitor select value
  localparam wb_addr_t reg_aw_bursts          = 5'd1;
  localparam wb_addr_t reg_w_bursts           = 5'd2;
  localparam wb_addr_t reg_w_beats            = 5'd3;
  localparam wb_addr_t reg_awlen_min          = 5'd4;
  localparam wb_addr_t reg_awlen_max          = 5'd5;
  localparam wb_addr_t reg_aw_bytes_min       = 5'd6;
  localparam wb_addr_t reg_aw_bytes_max       = 5'd7;
  localparam wb_addr_t reg_aw_bytes_sum       = 5'd8;
  localparam wb_addr_t reg_w_bytes_min        = 5'd9;
  localparam wb_addr_t reg_w_bytes_max        = 5'd10;
  localparam wb_addr_t reg_w_bytes_sum        = 5'd11;
  localparam wb_addr_t reg_aw_outstanding_max = 5'd12;
  localparam wb_addr_t reg_w_outstanding_max  = 5'd13;

  // cycle bins
  localparam wb_addr_t reg_idle        = 5'd14;
  localparam wb_addr_t reg_slow_data   = 5'd15;
  localparam wb_addr_t reg_stall       = 5'd16;
  localparam wb_addr_t reg_early_beat  = 5'd17;
  localparam wb_addr_t reg_awr_early   = 5'd18;
  localparam wb_addr_t reg_addr_stall  = 5'd19;
  localparam wb_addr_t reg_data_lag    = 5'd20;
  localparam wb_addr_t reg_addr_lag    = 5'd21;
  localparam wb_addr_t reg_early_stall = 5'd22;
  localparam wb_addr_t reg_b_lag       = 5'd23;
  localparam wb_addr_t reg_b_stall     = 5'd24;
  localparam wb_addr_t reg_b_end       = 5'd25;

endpackage

`default_nettype wire

/* src/stat_value.sv */
`timescale 1ns/1ps
`default_nettype none

module stat_value
  import axi_perf_pkg::*;
#(
  parameter int width = 8
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              clear,
  input  wire              en,
  input  wire [width-1:0]  val,
  output logic [width-1:0] min_val,
  output logic [width-1:0] max_val,
  output stat_t            sum
);

  // set once the first sample since clear has been taken
  logic valid;

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      valid   <= 1'b0;
      min_val <= '0;
      max_val <= '0;
      sum     <= '0;
    end else if (en) begin
      valid <= 1'b1;
      sum   <= sum + stat_t'(val);
      if (!valid) begin
        // first sample seeds both limits
        min_val <= val;
        max_val <= val;
      end else begin
        if (val < min_val) begin
          min_val <= val;
        end
        if (val > max_val) begin
          max_val <= val;
        end
      end
    end
  end

  a_min_le_max: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> (min_val <= max_val))
    else $error("stat_value: minimum above maximum");

endmodule

`default_nettype wire

/* verif/axi_wr_perf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_perf_tb
  import axi_perf_pkg::*;
  import stat_regs_pkg::*;
();

  localparam int clk_period      = 40;
  localparam int drive_delay     = 2;
  localparam int reset_cycles    = 5;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 300;
  // six test budgets plus reset and margin
  localparam int watchdog_cycles = num_tests * cycles_per_test + 200;
  localparam int ack_timeout     = 8;

  logic      clk;
  logic      rst_n;
  logic      awvalid;
  logic      awready;
  axi_addr_t awaddr;
  axi_id_t   awid;
  axi_len_t  awlen;
  axi_size_t awsize;
  logic [1:0] awburst;
  logic      wvalid;
  logic      wready;
  logic      wlast;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      bvalid;
  logic      bready;
  axi_id_t   bid;
  logic [1:0] bresp;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  wb_addr_t  wb_adr;
  wb_data_t  wb_dat_w;
  wb_data_t  wb_dat_r;
  logic      wb_ack;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          tests_run;

  // reference model state
  logic [31:0] ref_aw_bursts;
  logic [31:0] ref_w_bursts;
  logic [31:0] ref_w_beats;
  logic [31:0] ref_aw_out;
  logic [31:0] ref_aw_peak;
  logic [31:0] ref_w_out;
  logic [31:0] ref_w_peak;
  logic        ref_err;
  // slot 0 awlen, slot 1 aw bytes, slot 2 w bytes
  logic [31:0] ref_min [3];
  logic [31:0] ref_max [3];
  logic [31:0] ref_sum [3];
  logic        ref_seen [3];

  axi_wr_perf_top i_dut (
    .clk(clk), .rst_n(rst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid),
    .awlen(awlen), .awsize(awsize), .awburst(awburst),
    .wvalid(wvalid), .wready(wready), .wlast(wlast), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  // stepped once for every bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    logic        lsb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      bits = {bits[30:0], lsb};
    end
    return bits;
  endfunction

  task automatic reset_model();
    ref_aw_bursts = '0;
    ref_w_bursts  = '0;
    ref_w_beats   = '0;
    ref_aw_out    = '0;
    ref_aw_peak   = '0;
    ref_w_out     = '0;
    ref_w_peak    = '0;
    ref_err       = 1'b0;
    for (int k = 0; k < 3; k++) begin
      ref_min[k]  = '0;
      ref_max[k]  = '0;
      ref_sum[k]  = '0;
      ref_seen[k] = 1'b0;
    end
  endtask

  task automatic sample_value(input int k, input logic [31:0] v);
    if (!ref_seen[k] || v < ref_min[k]) begin
      ref_min[k] = v;
    end
    if (!ref_seen[k] || v > ref_max[k]) begin
      ref_max[k] = v;
    end
    ref_sum[k]  = ref_sum[k] + v;
    ref_seen[k] = 1'b1;
  endtask

  function automatic logic [31:0] expected_stat(input wb_addr_t adr);
    case (adr)
      reg_ctrl:               return {31'b0, ref_err};
      reg_aw_bursts:          return ref_aw_bursts;
      reg_w_bursts:           return ref_w_bursts;
      reg_w_beats:            return ref_w_beats;
      reg_awlen_min:          return ref_min[0];
      reg_awlen_max:          return ref_max[0];
      reg_aw_bytes_min:       return ref_min[1];
      reg_aw_bytes_max:       return ref_max[1];
      reg_aw_bytes_sum:       return ref_sum[1];
      reg_w_bytes_min:        return ref_min[2];
      reg_w_bytes_max:        return ref_max[2];
      reg_w_bytes_sum:        return ref_sum[2];
      reg_aw_outstanding_max: return ref_aw_peak;
      reg_w_outstanding_max:  return ref_w_peak;
      default:                return '0;
    endcase
  endfunction

  task automatic aw_send(input axi_len_t len, input axi_size_t size);
    logic [31:0] bytes;
    // number of beats times bytes per beat
    bytes   = (32'(len) + 32'd1) * (32'd1 << size);
    awvalid = 1'b1;
    awready = 1'b1;
    awaddr  = axi_addr_t'(ref_aw_bursts << 8);
    awid    = axi_id_t'(ref_aw_bursts);
    awlen   = len;
    awsize  = size;
    awburst = 2'b01;
    @(posedge clk);
    #drive_delay;
    awvalid = 1'b0;
    awready = 1'b0;
    ref_aw_bursts = ref_aw_bursts + 32'd1;
    ref_aw_out    = ref_aw_out + 32'd1;
    if (ref_aw_out > ref_aw_peak) begin
      ref_aw_peak = ref_aw_out;
    end
    sample_value(0, 32'(len));
    sample_value(1, bytes);
  endtask

  task automatic w_burst(input int beats);
    axi_strb_t strb;
    for (int b = 0; b < beats; b++) begin
      strb   = axi_strb_t'(lfsr_bits(axi_strb_width));
      wvalid = 1'b1;
      wready = 1'b1;
      wlast  = (b == beats - 1);
      wdata  = axi_data_t'(b);
      wstrb  = strb;
      @(posedge clk);
      #drive_delay;
      ref_w_beats = ref_w_beats + 32'd1;
      sample_value(2, 32'($countones(strb)));
    end
    wvalid = 1'b0;
    wready = 1'b0;
    wlast  = 1'b0;
    ref_w_bursts = ref_w_bursts + 32'd1;
    ref_w_out    = ref_w_out + 32'd1;
    if (ref_w_out > ref_w_peak) begin
      ref_w_peak = ref_w_out;
    end
  endtask

  task automatic b_send();
    bvalid = 1'b1;
    bready = 1'b1;
    bid    = '0;
    bresp  = 2'b00;
    @(posedge clk);
    #drive_delay;
    bvalid = 1'b0;
    bready = 1'b0;
    // a response needs both an address and a finished data burst
    if (ref_aw_out == '0 || ref_w_out == '0) begin
      ref_err = 1'b1;
    end
    if (ref_aw_out != '0) begin
      ref_aw_out = ref_aw_out - 32'd1;
    end
    if (ref_w_out != '0) begin
      ref_w_out = ref_w_out - 32'd1;
    end
  endtask

  task automatic wb_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                          output wb_data_t rdata);
    int   waited;
    logic got_ack;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    got_ack  = 1'b0;
    rdata    = '0;
    while (!got_ack && waited < ack_timeout) begin
      @(posedge clk);
      #drive_delay;
      waited++;
      if (wb_ack) begin
        got_ack = 1'b1;
        rdata   = wb_dat_r;
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    checks++;
    assert (got_ack && waited == 1) else begin
      $display("Wishbone ack for address %0d missing or late at time %0t", adr, $time);
      errors++;
    end
    // idle cycle where a pending clear takes effect
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic wb_read(input wb_addr_t adr, input logic [31:0] exp);
    wb_data_t rdata;
    wb_cycle(1'b0, adr, '0, rdata);
    checks++;
    assert (rdata == exp) else begin
      $display("Mismatch at %0t: register %0d read 0x%08h, expected 0x%08h",
               $time, adr, rdata, exp);
      errors++;
    end
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t discard;
    wb_cycle(1'b1, adr, dat, discard);
  endtask

  task automatic clear_stats();
    wb_write(reg_ctrl, wb_data_t'(1) << ctrl_clear_bit);
    reset_model();
  endtask

  // control and all non-bin statistics against the model
  task automatic compare_model();
    for (int a = 0; a <= int'(reg_w_outstanding_max); a++) begin
      wb_read(wb_addr_t'(a), expected_stat(wb_addr_t'(a)));
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    $display("test %s: %s, %0d errors", name,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  task automatic test_reset_state();
    int       e0;
    wb_data_t idle_now;
    e0 = errors;
    wb_read(reg_ctrl, '0);
    for (int a = 1; a < num_stats; a++) begin
      // the idle bin counts every cycle since reset
      if (wb_addr_t'(a) != reg_idle) begin
        wb_read(wb_addr_t'(a), '0);
      end
    end
    wb_cycle(1'b0, reg_idle, '0, idle_now);
    checks++;
    assert (idle_now != '0) else begin
      $display("idle counter did not count after reset at time %0t", $time);
      errors++;
    end
    finish_test("reset_state", e0);
  endtask

  task automatic test_burst_accounting();
    int e0;
    e0 = errors;
    clear_stats();
    for (int i = 0; i < 6; i++) begin
      aw_send(axi_len_t'(lfsr_bits(4)), axi_size_t'(lfsr_bits(1)));
    end
    compare_model();
    finish_test("burst_accounting", e0);
  endtask

  task automatic test_beat_accounting();
    int e0;
    e0 = errors;
    clear_stats();
    for (int i = 0; i < 4; i++) begin
      w_burst(int'(lfsr_bits(2)) + 1);
    end
    compare_model();
    finish_test("beat_accounting", e0);
  endtask

  task automatic test_outstanding_peaks();
    int e0;
    e0 = errors;
    clear_stats();
    for (int i = 0; i < 3; i++) begin
      aw_send(axi_len_t'(0), axi_size_t'(1));
    end
    for (int i = 0; i < 3; i++) begin
      w_burst(1);
    end
    for (int i = 0; i < 3; i++) begin
      b_send();
    end
    wb_read(reg_aw_outstanding_max, 32'd3);
    wb_read(reg_w_outstanding_max, 32'd3);
    compare_model();
    finish_test("outstanding_peaks", e0);
  endtask

  task automatic test_clear_idle();
    int       e0;
    wb_data_t idle_first;
    wb_data_t idle_second;
    e0 = errors;
    clear_stats();
    compare_model();
    wb_cycle(1'b0, reg_idle, '0, idle_first);
    for (int a = int'(reg_slow_data); a <= int'(reg_b_end); a++) begin
      wb_read(wb_addr_t'(a), '0);
    end
    wb_cycle(1'b0, reg_idle, '0, idle_second);
    checks++;
    assert (idle_first != '0 && idle_second > idle_first) else begin
      $display("idle counter did not grow on an idle bus at time %0t (%0d then %0d)",
               $time, idle_first, idle_second);
      errors++;
    end
    finish_test("clear_idle", e0);
  endtask

  task automatic test_error_flag();
    int e0;
    e0 = errors;
    clear_stats();
    b_send();
    wb_read(reg_ctrl, 32'd1);
    wb_read(reg_ctrl, 32'd1);
    // address outstanding but no finished data burst
    clear_stats();
    aw_send(axi_len_t'(0), axi_size_t'(0));
    b_send();
    wb_read(reg_ctrl, 32'd1);
    // finished data burst but no address
    clear_stats();
    w_burst(1);
    b_send();
    wb_read(reg_ctrl, 32'd1);
    clear_stats();
    wb_read(reg_ctrl, 32'd0);
    finish_test("error_flag", e0);
  endtask

  initial begin
    rst_n    = 1'b0;
    awvalid  = 1'b0;
    awready  = 1'b0;
    awaddr   = '0;
    awid     = '0;
    awlen    = '0;
    awsize   = '0;
    awburst  = '0;
    wvalid   = 1'b0;
    wready   = 1'b0;
    wlast    = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    bvalid   = 1'b0;
    bready   = 1'b0;
    bid      = '0;
    bresp    = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    lfsr_state = 32'h8616_850b;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    reset_model();

    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;

    test_reset_state();
    test_burst_accounting();
    test_beat_accounting();
    test_outstanding_peaks();
    test_clear_idle();
    test_error_flag();

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
